// ==== source/adc_display_settings.svh ====
// timing and address settings for the adc monitor
// defaults are sized for simulation
`ifndef ADC_DISPLAY_SETTINGS_SVH
`define ADC_DISPLAY_SETTINGS_SVH

// i2c address of the adc and the register polled
`define ADC_DEVICE_ID 7'h54
`define ADC_REG_ADDR 8'h00

// clock cycles per quarter scl period
`define I2C_QUARTER_CYCLES 5

// idle cycles between the end of a read and the next request
`define POLL_INTERVAL_CYCLES 200

// display, keys and buzzer
`define SCAN_CYCLES 16
`define DEBOUNCE_CYCLES 40
`define BEEP_CYCLES 300
`define TONE_HALF_CYCLES 10

`endif

// ==== source/i2c_pkg.sv ====
// i2c controller phases
// address byte with its two views
package i2c_pkg;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_SEND,
		ST_GET_ACK,
		ST_RESTART,
		ST_READ,
		ST_NACK,
		ST_STOP
	} i2c_state_t;

	// r/w bit values
	localparam logic I2C_WRITE = 1'b0;
	localparam logic I2C_READ = 1'b1;

	// same byte seen as address plus r/w, or as shifted raw bits
	typedef union packed {
		struct packed {
			logic [6:0] addr;
			logic rw;
		} fields;
		logic [7:0] raw;
	} i2c_addr_byte_u;

endpackage

// ==== source/display_pkg.sv ====
// seven-segment display types
// digit codes and the eight-digit display word
package display_pkg;

	// 0 to 9 are numerals
	typedef logic [3:0] digit_code_t;

	// lights no segment
	localparam digit_code_t DIGIT_BLANK = 4'd10;
	// channel marker, a dash
	localparam digit_code_t DIGIT_MARK = 4'd15;

	// index 0 is the rightmost digit
	typedef digit_code_t [7:0] display_word_t;

endpackage

// ==== source/i2c_req_if.sv ====
// request and response signals between the poller and the i2c master
`timescale 1ns/100ps

interface i2c_req_if;

	logic req;
	logic ready;
	logic [7:0] rd_data;
	logic rd_valid;
	logic nack_err;

	modport poller (
		output req,
		input ready,
		input rd_data,
		input rd_valid,
		input nack_err
	);

	modport master (
		input req,
		output ready,
		output rd_data,
		output rd_valid,
		output nack_err
	);

endinterface

// ==== source/i2c_master.sv ====
// i2c master, one register read per request
// write address, register, repeated start, read one byte, nack, stop
`timescale 1ns/100ps
`include "adc_display_settings.svh"

module i2c_master (
	input logic clk,
	input logic rst,
	i2c_req_if.master bus,
	output logic scl,
	inout wire sda
);
	import i2c_pkg::*;

	localparam int QC = `I2C_QUARTER_CYCLES;
	localparam int DW = $clog2(QC + 1);

	i2c_state_t state;
	logic [DW-1:0] div;
	logic tick;
	logic [1:0] q;
	logic [2:0] bit_cnt;
	logic [1:0] byte_cnt;
	logic [7:0] shift;
	logic sda_low;
	logic aborted;
	i2c_addr_byte_u addr_wr;
	i2c_addr_byte_u addr_rd;

	always_comb begin
		addr_wr.fields.addr = `ADC_DEVICE_ID;
		addr_wr.fields.rw = I2C_WRITE;
		addr_rd.fields.addr = `ADC_DEVICE_ID;
		addr_rd.fields.rw = I2C_READ;
	end

	// open drain, only pulled low or released
	assign sda = sda_low ? 1'b0 : 1'bz;
	assign tick = (div == DW'(QC - 1));
	assign bus.ready = (state == ST_IDLE);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= ST_IDLE;
			div <= '0;
			q <= 2'd0;
			bit_cnt <= 3'd0;
			byte_cnt <= 2'd0;
			shift <= 8'h00;
			sda_low <= 1'b0;
			scl <= 1'b1;
			aborted <= 1'b0;
			bus.rd_data <= 8'h00;
			bus.rd_valid <= 1'b0;
			bus.nack_err <= 1'b0;
		end else begin
			bus.rd_valid <= 1'b0;
			bus.nack_err <= 1'b0;
			if (state == ST_IDLE) begin
				div <= '0;
				q <= 2'd0;
				if (bus.req) begin
					state <= ST_START;
					aborted <= 1'b0;
					byte_cnt <= 2'd0;
				end
			end else begin
				div <= tick ? '0 : div + 1'b1;
				if (tick) begin
					q <= q + 1'b1;
					// every bit raises scl in its second quarter
					if (q == 2'd1)
						scl <= 1'b1;
					case (state)
						ST_START, ST_RESTART: begin
							if (q == 2'd0)
								sda_low <= 1'b0;
							else if (q == 2'd2)
								sda_low <= 1'b1;
							else if (q == 2'd3) begin
								scl <= 1'b0;
								bit_cnt <= 3'd7;
								shift <= (state == ST_START) ? addr_wr.raw : addr_rd.raw;
								state <= ST_SEND;
							end
						end
						ST_SEND: begin
							if (q == 2'd0)
								sda_low <= ~shift[7];
							else if (q == 2'd3) begin
								scl <= 1'b0;
								shift <= {shift[6:0], 1'b0};
								if (bit_cnt == 3'd0)
									state <= ST_GET_ACK;
								else
									bit_cnt <= bit_cnt - 1'b1;
							end
						end
						ST_GET_ACK: begin
							if (q == 2'd0)
								sda_low <= 1'b0;
							else if (q == 2'd3) begin
								scl <= 1'b0;
								bit_cnt <= 3'd7;
								if (sda) begin
									// no ack from the slave
									aborted <= 1'b1;
									state <= ST_STOP;
								end else if (byte_cnt == 2'd0) begin
									shift <= `ADC_REG_ADDR;
									byte_cnt <= 2'd1;
									state <= ST_SEND;
								end else if (byte_cnt == 2'd1) begin
									byte_cnt <= 2'd2;
									state <= ST_RESTART;
								end else begin
									state <= ST_READ;
								end
							end
						end
						ST_READ: begin
							if (q == 2'd0)
								sda_low <= 1'b0;
							else if (q == 2'd2)
								shift <= {shift[6:0], sda};
							else if (q == 2'd3) begin
								scl <= 1'b0;
								if (bit_cnt == 3'd0)
									state <= ST_NACK;
								else
									bit_cnt <= bit_cnt - 1'b1;
							end
						end
						ST_NACK: begin
							// released sda is the nack
							if (q == 2'd0)
								sda_low <= 1'b0;
							else if (q == 2'd3) begin
								scl <= 1'b0;
								state <= ST_STOP;
							end
						end
						default: begin
							// stop, sda rises while scl is high
							if (q == 2'd0)
								sda_low <= 1'b1;
							else if (q == 2'd2)
								sda_low <= 1'b0;
							else if (q == 2'd3) begin
								state <= ST_IDLE;
								bus.rd_data <= shift;
								bus.rd_valid <= ~aborted;
								bus.nack_err <= aborted;
							end
						end
					endcase
				end
			end
		end
	end

endmodule

// ==== source/adc_poller.sv ====
// periodic adc read scheduler
// holds the latest sample, stops requesting while hold is set
`timescale 1ns/100ps
`include "adc_display_settings.svh"

module adc_poller (
	input logic clk,
	input logic rst,
	i2c_req_if.poller bus,
	input logic hold,
	output logic [7:0] sample,
	output logic sample_stb
);

	localparam int PI = `POLL_INTERVAL_CYCLES;
	localparam int CW = $clog2(PI + 1);

	logic [CW-1:0] wait_cnt;
	logic wait_done;

	assign wait_done = (wait_cnt == CW'(PI - 1));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wait_cnt <= '0;
			bus.req <= 1'b0;
			sample <= 8'h00;
			sample_stb <= 1'b0;
		end else begin
			bus.req <= 1'b0;
			sample_stb <= 1'b0;
			if (bus.rd_valid) begin
				sample <= bus.rd_data;
				sample_stb <= 1'b1;
			end
			// wait starts over when a read ends, with data or with a nack
			if (bus.rd_valid || bus.nack_err) begin
				wait_cnt <= '0;
			end else if (bus.ready && !bus.req) begin
				if (!wait_done)
					wait_cnt <= wait_cnt + 1'b1;
				else if (!hold)
					bus.req <= 1'b1;
			end
		end
	end

endmodule

// ==== source/sample_formatter.sv ====
// sample to decimal display word
// right-aligned, leading blanks, marker in digit 7
`timescale 1ns/100ps

module sample_formatter (
	input logic clk,
	input logic rst,
	input logic [7:0] sample,
	input logic sample_stb,
	output display_pkg::display_word_t display_word
);
	import display_pkg::*;

	localparam display_word_t EMPTY_WORD = {DIGIT_MARK, {7{DIGIT_BLANK}}};

	logic [7:0] hundreds;
	logic [7:0] tens;
	logic [7:0] ones;
	display_word_t next_word;

	// digits come straight from the current sample
	always_comb begin
		hundreds = sample / 8'd100;
		tens = (sample / 8'd10) % 8'd10;
		ones = sample % 8'd10;
		next_word = EMPTY_WORD;
		next_word[0] = ones[3:0];
		if (sample >= 8'd10)
			next_word[1] = tens[3:0];
		if (sample >= 8'd100)
			next_word[2] = hundreds[3:0];
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			display_word <= EMPTY_WORD;
		end else if (sample_stb) begin
			display_word <= next_word;
		end
	end

endmodule

// ==== source/seg_scan.sv ====
// eight-digit display scanning
// seven-segment decode of the lit digit, active-low outputs
`timescale 1ns/100ps
`include "adc_display_settings.svh"

module seg_scan (
	input logic clk,
	input logic rst,
	input display_pkg::display_word_t display_word,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);
	import display_pkg::*;

	localparam int SC = `SCAN_CYCLES;
	localparam int SW = $clog2(SC + 1);

	logic [SW-1:0] dwell;
	logic [2:0] lit;
	logic active;
	digit_code_t code;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			dwell <= '0;
			lit <= 3'd0;
			active <= 1'b0;
		end else if (dwell == SW'(SC - 1)) begin
			dwell <= '0;
			// first step lights digit 0
			if (!active)
				active <= 1'b1;
			else
				lit <= lit + 1'b1;
		end else begin
			dwell <= dwell + 1'b1;
		end
	end

	assign seg_choice = active ? ~(8'h01 << lit) : 8'hff;
	assign code = display_word[lit];

	// bit 7 is the decimal point, kept off
	always_comb begin
		case (code)
			4'd0: seg_number = 8'hc0;
			4'd1: seg_number = 8'hf9;
			4'd2: seg_number = 8'ha4;
			4'd3: seg_number = 8'hb0;
			4'd4: seg_number = 8'h99;
			4'd5: seg_number = 8'h92;
			4'd6: seg_number = 8'h82;
			4'd7: seg_number = 8'hf8;
			4'd8: seg_number = 8'h80;
			4'd9: seg_number = 8'h90;
			DIGIT_MARK: seg_number = 8'hbf;
			default: seg_number = 8'hff;
		endcase
	end

endmodule

// ==== source/key_panel.sv ====
// key debounce and press detection
// hold toggle on key 0, buzzer beep on any press
`timescale 1ns/100ps
`include "adc_display_settings.svh"

module key_panel (
	input logic clk,
	input logic rst,
	input logic [3:0] key_in,
	output logic hold,
	output logic buzzer
);

	localparam int DB = `DEBOUNCE_CYCLES;
	localparam int DBW = $clog2(DB + 1);
	localparam int BC = `BEEP_CYCLES;
	localparam int BW = $clog2(BC + 1);
	localparam int TH = `TONE_HALF_CYCLES;
	localparam int TW = $clog2(TH + 1);

	logic [3:0] key_meta;
	logic [3:0] key_sync;
	logic [3:0] key_level;
	logic [3:0] press;
	logic [DBW-1:0] db_cnt [4];
	logic [BW-1:0] beep_cnt;
	logic [TW-1:0] tone_cnt;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			key_meta <= 4'hf;
			key_sync <= 4'hf;
			key_level <= 4'hf;
			press <= 4'h0;
			for (int i = 0; i < 4; i++)
				db_cnt[i] <= '0;
		end else begin
			key_meta <= key_in;
			key_sync <= key_meta;
			for (int i = 0; i < 4; i++) begin
				press[i] <= 1'b0;
				if (key_sync[i] == key_level[i]) begin
					db_cnt[i] <= '0;
				end else if (db_cnt[i] == DBW'(DB - 1)) begin
					db_cnt[i] <= '0;
					key_level[i] <= key_sync[i];
					// falling debounced level
					press[i] <= ~key_sync[i];
				end else begin
					db_cnt[i] <= db_cnt[i] + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			hold <= 1'b0;
			buzzer <= 1'b0;
			beep_cnt <= '0;
			tone_cnt <= '0;
		end else begin
			if (press[0])
				hold <= ~hold;
			if (|press) begin
				beep_cnt <= BW'(BC);
				tone_cnt <= '0;
				buzzer <= 1'b1;
			end else if (beep_cnt != '0) begin
				beep_cnt <= beep_cnt - 1'b1;
				if (beep_cnt == BW'(1)) begin
					buzzer <= 1'b0;
				end else if (tone_cnt == TW'(TH - 1)) begin
					tone_cnt <= '0;
					buzzer <= ~buzzer;
				end else begin
					tone_cnt <= tone_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== source/adc_display_top.sv ====
// adc monitor top level
// i2c polling, led and seven-segment output, keys and buzzer
`timescale 1ns/100ps

module adc_display_top (
	input logic clk,
	input logic rst,
	input logic [3:0] key_in,
	output logic buzzer,
	output logic [7:0] led,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice,
	output logic scl,
	inout wire sda
);

	logic hold;
	logic [7:0] sample;
	logic sample_stb;
	display_pkg::display_word_t display_word;

	i2c_req_if i2c_bus ();

	i2c_master i_i2c_master (
		.clk (clk),
		.rst (rst),
		.bus (i2c_bus.master),
		.scl (scl),
		.sda (sda)
	);

	adc_poller i_adc_poller (
		.clk (clk),
		.rst (rst),
		.bus (i2c_bus.poller),
		.hold (hold),
		.sample (sample),
		.sample_stb (sample_stb)
	);

	sample_formatter i_sample_formatter (
		.clk (clk),
		.rst (rst),
		.sample (sample),
		.sample_stb (sample_stb),
		.display_word (display_word)
	);

	seg_scan i_seg_scan (
		.clk (clk),
		.rst (rst),
		.display_word (display_word),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

	key_panel i_key_panel (
		.clk (clk),
		.rst (rst),
		.key_in (key_in),
		.hold (hold),
		.buzzer (buzzer)
	);

	// raw sample on the leds
	assign led = sample;

endmodule

// ==== tb/adc_slave_model.sv ====
// behavioural i2c adc slave for the testbench
// returns queued sample bytes, records returned bytes, flags protocol errors
`timescale 1ns/100ps
`include "adc_display_settings.svh"

module adc_slave_model (
	input logic scl,
	inout wire sda,
	output logic proto_err
);
	import i2c_pkg::*;

	logic drive_low;
	logic withhold_ack;
	int start_cnt;
	int nack_cnt;
	logic [7:0] byte_q[$];
	logic [7:0] sent_q[$];

	assign sda = drive_low ? 1'b0 : 1'bz;

	initial begin
		drive_low = 1'b0;
		withhold_ack = 1'b0;
		proto_err = 1'b0;
		start_cnt = 0;
		nack_cnt = 0;
	end

	task automatic wait_start();
		do @(negedge sda); while (scl !== 1'b1);
	endtask

	task automatic wait_stop();
		do @(posedge sda); while (scl !== 1'b1);
	endtask

	// bits are taken on the rising scl edge, msb first
	task automatic get_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			@(posedge scl);
			b = {b[6:0], sda};
		end
	endtask

	task automatic send_ack();
		@(negedge scl);
		drive_low = 1'b1;
		@(negedge scl);
		drive_low = 1'b0;
	endtask

	// every start, repeated starts too
	always @(negedge sda) begin
		if (scl === 1'b1)
			start_cnt++;
	end

	always begin : transaction
		i2c_addr_byte_u a;
		logic [7:0] b;
		logic [7:0] d;
		wait_start();
		get_byte(a.raw);
		if (a.fields.addr != `ADC_DEVICE_ID || a.fields.rw != I2C_WRITE)
			proto_err = 1'b1;
		if (withhold_ack) begin
			// address not acknowledged this once
			withhold_ack = 1'b0;
			nack_cnt++;
			wait_stop();
		end else begin
			send_ack();
			get_byte(b);
			if (b != `ADC_REG_ADDR)
				proto_err = 1'b1;
			send_ack();
			wait_start();
			get_byte(a.raw);
			if (a.fields.addr != `ADC_DEVICE_ID || a.fields.rw != I2C_READ)
				proto_err = 1'b1;
			d = (byte_q.size() != 0) ? byte_q.pop_front() : 8'h00;
			send_ack();
			drive_low = ~d[7];
			for (int i = 6; i >= 0; i--) begin
				@(negedge scl);
				drive_low = ~d[i];
			end
			@(negedge scl);
			drive_low = 1'b0;
			// master must not acknowledge the last byte
			@(posedge scl);
			if (sda !== 1'b1)
				proto_err = 1'b1;
			wait_stop();
			sent_q.push_back(d);
		end
	end

endmodule

// ==== tb/adc_display_props.sv ====
// assertions on the top-level i2c, display and buzzer ports
`timescale 1ns/100ps

module adc_display_props (
	input logic clk,
	input logic rst,
	input logic scl,
	input wire sda,
	input logic [7:0] seg_choice,
	input logic buzzer,
	input logic edge_phase,
	input logic beep_active
);

	int fail_cnt;

	initial fail_cnt = 0;

	// sda only moves under a high scl during start or stop phases
	property sda_stable_high;
		@(posedge clk) disable iff (!rst)
		(scl && $past(scl) && (sda != $past(sda))) |-> edge_phase;
	endproperty

	// one digit at most, and the lit digit steps left by one
	property one_digit_lit;
		@(posedge clk) disable iff (!rst)
		$onehot0(~seg_choice) && ($stable(seg_choice) || $past(seg_choice) == 8'hff ||
			seg_choice == $past({seg_choice[6:0], seg_choice[7]}));
	endproperty

	property buzzer_quiet;
		@(posedge clk) disable iff (!rst) buzzer |-> beep_active;
	endproperty

	a_sda_stable: assert property (sda_stable_high)
		else begin
			fail_cnt++;
			$error("sda changed while scl high outside start or stop");
		end
	a_one_digit: assert property (one_digit_lit)
		else begin
			fail_cnt++;
			$error("digit select not one-hot or out of scan order");
		end
	a_buzzer: assert property (buzzer_quiet)
		else begin
			fail_cnt++;
			$error("buzzer active outside a beep");
		end

endmodule

bind adc_display_top adc_display_props i_adc_display_props (
	.clk (clk),
	.rst (rst),
	.scl (scl),
	.sda (sda),
	.seg_choice (seg_choice),
	.buzzer (buzzer),
	.edge_phase ((i_i2c_master.state == i2c_pkg::ST_START) ||
		(i_i2c_master.state == i2c_pkg::ST_RESTART) ||
		(i_i2c_master.state == i2c_pkg::ST_STOP)),
	.beep_active (i_key_panel.beep_cnt != '0)
);

// ==== tb/adc_display_tb.sv ====
// testbench for the adc monitor top level
// clock, reset, key stimulus, sample and display compare, timeout
`timescale 1ns/100ps
`include "adc_display_settings.svh"

module adc_display_tb;
	import display_pkg::*;

	localparam int N_SAMPLES = 12;
	localparam int QC = `I2C_QUARTER_CYCLES;
	localparam int POLL = `POLL_INTERVAL_CYCLES;
	localparam int TXN_CYCLES = 40 * 4 * QC;
	localparam int SCAN_ALL = 8 * `SCAN_CYCLES;
	localparam int KEY_CYCLES = 3 * (2 * `DEBOUNCE_CYCLES + 40) + `BEEP_CYCLES
		+ 2 * `TONE_HALF_CYCLES;
	localparam int HOLD_CYCLES = TXN_CYCLES + 200 + 3 * POLL + SCAN_ALL;
	localparam int LIMIT = 2 * ((N_SAMPLES + 2) * (POLL + TXN_CYCLES) + KEY_CYCLES
		+ HOLD_CYCLES);

	logic clk;
	logic rst;
	logic [3:0] key_in;
	logic buzzer;
	logic [7:0] led;
	logic [7:0] seg_number;
	logic [7:0] seg_choice;
	logic scl;
	wire sda;
	logic proto_err;
	int cycles;
	int checked;

	pullup (sda);

	adc_display_top i_adc_display_top (
		.clk (clk),
		.rst (rst),
		.key_in (key_in),
		.buzzer (buzzer),
		.led (led),
		.seg_number (seg_number),
		.seg_choice (seg_choice),
		.scl (scl),
		.sda (sda)
	);

	adc_slave_model adc_slave (
		.scl (scl),
		.sda (sda),
		.proto_err (proto_err)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// decimal, right-aligned, leading blanks, dash in digit 7
	function automatic display_word_t expected_word(input logic [7:0] s);
		display_word_t w;
		int v;
		v = s;
		for (int i = 0; i < 7; i++)
			w[i] = DIGIT_BLANK;
		w[7] = DIGIT_MARK;
		w[0] = digit_code_t'(v % 10);
		if (v >= 10)
			w[1] = digit_code_t'((v / 10) % 10);
		if (v >= 100)
			w[2] = digit_code_t'(v / 100);
		return w;
	endfunction

	// active-low a to g, decimal point off
	function automatic logic [7:0] segment_pattern(input digit_code_t c);
		case (c)
			4'd0: return 8'hc0;
			4'd1: return 8'hf9;
			4'd2: return 8'ha4;
			4'd3: return 8'hb0;
			4'd4: return 8'h99;
			4'd5: return 8'h92;
			4'd6: return 8'h82;
			4'd7: return 8'hf8;
			4'd8: return 8'h80;
			4'd9: return 8'h90;
			DIGIT_MARK: return 8'hbf;
			default: return 8'hff;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// one full scan, every lit digit against the expected word
	task automatic check_display(input logic [7:0] value);
		display_word_t w;
		logic [7:0] seen;
		w = expected_word(value);
		seen = 8'h00;
		repeat (SCAN_ALL) begin
			@(negedge clk);
			for (int i = 0; i < 8; i++) begin
				if (seg_choice[i] == 1'b0) begin
					seen[i] = 1'b1;
					check("seg_number", seg_number, segment_pattern(w[i]));
				end
			end
		end
		check("digits scanned", seen, 8'hff);
	endtask

	task automatic wait_checked(input int n);
		while (checked < n)
			@(negedge clk);
	endtask

	// bouncing press, then a steady low level
	task automatic press_key(input int k);
		for (int i = 0; i < 10; i++) begin
			key_in[k] = i[0];
			step(1);
		end
		key_in[k] = 1'b0;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout, run did not finish within %0d cycles", LIMIT);
			$display("tests failed");
			$fatal(1);
		end
		if (proto_err === 1'b1) begin
			$display("the ADC slave model saw a wrong I2C transaction");
			$display("tests failed");
			$fatal(1);
		end
		if (i_adc_display_top.i_adc_display_props.fail_cnt != 0) begin
			$display("an assertion on the DUT ports failed");
			$display("tests failed");
			$fatal(1);
		end
	end

	initial begin : compare_samples
		logic [7:0] b;
		@(posedge rst);
		forever begin
			@(negedge clk);
			if (adc_slave.sent_q.size() != 0) begin
				b = adc_slave.sent_q.pop_front();
				repeat (QC + 3) @(negedge clk);
				check("led", led, b);
				@(negedge clk);
				check_display(b);
				checked++;
			end
		end
	end

	initial begin : stimulus
		logic [31:0] seed;
		logic [7:0] led0;
		int n0;
		int toggles;
		int last_high;
		logic prev;
		cycles = 0;
		checked = 0;
		rst = 1'b0;
		key_in = 4'hf;
		seed = 32'h89f3a3ef;
		adc_slave.byte_q = '{8'd0, 8'd9, 8'd10, 8'd99, 8'd100, 8'd255};
		for (int i = 6; i < N_SAMPLES; i++) begin
			seed = lcg_next(seed);
			adc_slave.byte_q.push_back(seed[31:24]);
		end
		step(2);
		rst = 1'b1;
		@(negedge clk);
		check("scl", scl, 1'b1);
		check("sda", sda, 1'b1);
		check("buzzer", buzzer, 1'b0);
		check("seg_choice", seg_choice, 8'hff);

		// key 2 with bouncing gives one beep
		wait_checked(2);
		step(1);
		press_key(2);
		n0 = 0;
		while (buzzer !== 1'b1 && n0 < 2 * `DEBOUNCE_CYCLES) begin
			step(1);
			n0++;
		end
		check("buzzer started", buzzer, 1'b1);
		key_in[2] = 1'b1;
		toggles = 0;
		last_high = 0;
		prev = buzzer;
		for (int i = 1; i <= `BEEP_CYCLES + 4 * `TONE_HALF_CYCLES; i++) begin
			@(negedge clk);
			if (buzzer != prev)
				toggles++;
			if (buzzer)
				last_high = i;
			prev = buzzer;
		end
		check("beep toggles in range", (toggles >= `BEEP_CYCLES / `TONE_HALF_CYCLES - 2) &&
			(toggles <= `BEEP_CYCLES / `TONE_HALF_CYCLES + 1), 1);
		check("beep ends in time", last_high < `BEEP_CYCLES, 1);
		check("buzzer after beep", buzzer, 1'b0);

		// address nack once, old sample kept, next read succeeds
		wait_checked(4);
		step(1);
		adc_slave.withhold_ack = 1'b1;
		n0 = adc_slave.nack_cnt;
		while (adc_slave.nack_cnt == n0)
			@(negedge clk);
		led0 = led;
		// aborted read ends with a stop, nack_err follows a quarter later
		do @(posedge sda); while (scl !== 1'b1);
		repeat (2 * QC + 5) @(negedge clk);
		check("led after nack", led, led0);
		n0 = checked;
		wait_checked(n0 + 1);

		// hold on key 0
		step(1);
		press_key(0);
		step(`DEBOUNCE_CYCLES + 10);
		key_in[0] = 1'b1;
		step(TXN_CYCLES + 200);
		n0 = adc_slave.start_cnt;
		led0 = led;
		step(3 * POLL);
		check("starts during hold", adc_slave.start_cnt, n0);
		check("led during hold", led, led0);
		check_display(led0);
		step(1);
		press_key(0);
		step(`DEBOUNCE_CYCLES + 10);
		key_in[0] = 1'b1;
		n0 = checked;
		wait_checked(n0 + 1);

		wait_checked(N_SAMPLES);
		if (i_adc_display_top.i_adc_display_props.fail_cnt == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1);
		end
	end

endmodule

// ==== filelist.f ====
source/i2c_pkg.sv
source/display_pkg.sv
source/i2c_req_if.sv
source/i2c_master.sv
source/adc_poller.sv
source/sample_formatter.sv
source/seg_scan.sv
source/key_panel.sv
source/adc_display_top.sv
tb/adc_slave_model.sv
tb/adc_display_props.sv
tb/adc_display_tb.sv
+incdir+source
